//--- tb.f
+incdir+src
src/backend_pkg.sv
src/backend_if.sv
src/issue_stage.sv
src/rob.sv
src/commit_stage.sv
src/backend.sv
tb/tb_backend.sv

//--- run.sh
#!/bin/sh
# Build the backend testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_backend -o sim_backend \
    && ./obj_dir/sim_backend | grep -F '*** PASSED ***' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- tb/tb_backend.sv
// Random-stimulus testbench for the backend, checking each retired result against an in-order model
`timescale 1ns/1ps
`include "backend_cfg.svh"

module tb_backend import backend_pkg::*; ();

    localparam int NUM_INSTR  = 2000;
    localparam int MAX_CYCLES = NUM_INSTR * 8 + 100;

    // Model ALU operations
    localparam int OP_ADD = 0;
    localparam int OP_SUB = 1;
    localparam int OP_SLT = 2;
    localparam int OP_XOR = 3;
    localparam int OP_OR  = 4;
    localparam int OP_AND = 5;

    logic     clk_i;
    logic     rst_n_i;
    logic     fetch_valid_i;
    instr_t   fetch_instr_i;
    logic     fetch_ready_o;
    logic     retire_ready_i;
    logic     retire_valid_o;
    reg_idx_t retire_rd_idx_o;
    word_t    retire_value_o;

    backend UUT (
        .clk_i          (clk_i          ),
        .rst_n_i        (rst_n_i        ),
        .fetch_valid_i  (fetch_valid_i  ),
        .fetch_instr_i  (fetch_instr_i  ),
        .fetch_ready_o  (fetch_ready_o  ),
        .retire_ready_i (retire_ready_i ),
        .retire_valid_o (retire_valid_o ),
        .retire_rd_idx_o(retire_rd_idx_o),
        .retire_value_o (retire_value_o )
    );

    always #20 clk_i = ~clk_i;

    // ------------------------------------------------
    // Reference model state
    // ------------------------------------------------
    word_t       model_regs [`REG_NUM];
    rob_entry_t  expected_q [$];
    int          accepted_cnt;
    int          retired_cnt;
    int          cycle_cnt;

    // Fields of the instruction on the fetch port
    logic        cur_bad;
    logic        cur_is_imm;
    int          cur_op;
    reg_idx_t    cur_rd;
    reg_idx_t    cur_rs1;
    reg_idx_t    cur_rs2;
    logic [11:0] cur_imm;

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_rd(input string what, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("FAILED at %0t: %s is x%0d, expected x%0d",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_value(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("FAILED at %0t: %s is 0x%08h, expected 0x%08h",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("FAILED at %0t: %s is %b, expected %b",
                                      $time, what, got, exp));
        end
    endtask

    function automatic word_t alu_model(input int op, input word_t a, input word_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_SLT:  return ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
            OP_XOR:  return a ^ b;
            OP_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [2:0] funct3_of(input int op);
        case (op)
            OP_SLT:  return `FUNCT3_SLT;
            OP_XOR:  return `FUNCT3_XOR;
            OP_OR:   return `FUNCT3_OR;
            OP_AND:  return `FUNCT3_AND;
            default: return `FUNCT3_ADD;
        endcase
    endfunction

    // ------------------------------------------------
    // Stimulus and model execution
    // ------------------------------------------------
    task automatic make_instr(output logic [31:0] word);
        int         pick;
        int         sel;
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        pick       = $urandom_range(0, 99);
        cur_rd     = reg_idx_t'($urandom_range(0, 7));
        cur_rs1    = reg_idx_t'($urandom_range(0, 7));
        cur_rs2    = reg_idx_t'($urandom_range(0, 7));
        cur_imm    = 12'($urandom);
        cur_bad    = (pick < 5);
        cur_is_imm = 1'($urandom_range(0, 1));
        cur_op     = OP_ADD;
        if (cur_bad) begin
            if (pick < 3) begin
                // Load, store, branch or LUI opcode
                sel = $urandom_range(0, 3);
                opcode = (sel == 0) ? 7'b0000011 : (sel == 1) ? 7'b0100011
                       : (sel == 2) ? 7'b1100011 : 7'b0110111;
                funct3 = 3'($urandom_range(0, 7));
            end else begin
                // Shift codes are outside the ALU set
                opcode = cur_is_imm ? `OPCODE_OP_IMM : `OPCODE_OP;
                funct3 = $urandom_range(0, 1) ? 3'b001 : 3'b101;
            end
            word = {cur_imm, cur_rs1, funct3, cur_rd, opcode};
        end else if (cur_is_imm) begin
            sel    = $urandom_range(0, 4);
            cur_op = (sel == 0) ? OP_ADD : sel + 1;
            word   = {cur_imm, cur_rs1, funct3_of(cur_op), cur_rd, `OPCODE_OP_IMM};
        end else begin
            cur_op = $urandom_range(OP_ADD, OP_AND);
            funct7 = (cur_op == OP_SUB) ? 7'b0100000 : 7'b0000000;
            word   = {funct7, cur_rs2, cur_rs1, funct3_of(cur_op), cur_rd, `OPCODE_OP};
        end
    endtask

    task automatic execute_model();
        word_t      a;
        word_t      b;
        rob_entry_t e;
        e.rd_idx = '0;
        e.value  = '0;
        if (!cur_bad) begin
            a = model_regs[cur_rs1];
            b = cur_is_imm ? {{(`XLEN-12){cur_imm[11]}}, cur_imm} : model_regs[cur_rs2];
            e.rd_idx = cur_rd;
            e.value  = alu_model(cur_op, a, b);
            // x0 keeps reading zero
            if (cur_rd != '0) begin
                model_regs[cur_rd] = e.value;
            end
        end
        expected_q.push_back(e);
    endtask

    // ------------------------------------------------
    // Main sequence
    // ------------------------------------------------
    initial begin
        logic [31:0] word;
        logic        fetch_fire;
        logic        retire_fire;
        logic        hold_q;
        reg_idx_t    held_rd;
        word_t       held_value;
        int          phase_mode;
        int          phase_left;
        int          gen_cnt;

        void'($urandom(65));
        clk_i          = 1'b0;
        rst_n_i        = 1'b0;
        fetch_valid_i  = 1'b0;
        fetch_instr_i  = '0;
        retire_ready_i = 1'b0;
        for (int i = 0; i < `REG_NUM; i++) begin
            model_regs[i] = '0;
        end
        accepted_cnt = 0;
        retired_cnt  = 0;
        cycle_cnt    = 0;
        gen_cnt      = 0;
        fetch_fire   = 1'b0;
        hold_q       = 1'b0;
        held_rd      = '0;
        held_value   = '0;
        // First phase blocks retirement so the buffer fills up
        phase_mode   = 2;
        phase_left   = 30;

        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        #10;
        check_flag("retire_valid_o after reset", retire_valid_o, 1'b0);
        check_flag("fetch_ready_o after reset", fetch_ready_o, 1'b1);

        while (retired_cnt < NUM_INSTR && cycle_cnt < MAX_CYCLES) begin
            @(negedge clk_i);
            if (fetch_fire) begin
                fetch_valid_i = 1'b0;
            end
            if (!fetch_valid_i && gen_cnt < NUM_INSTR && $urandom_range(0, 99) < 85) begin
                make_instr(word);
                fetch_instr_i = word;
                fetch_valid_i = 1'b1;
                gen_cnt++;
            end
            // Retire back-pressure comes in phases
            if (phase_left == 0) begin
                phase_mode = $urandom_range(0, 2);
                phase_left = $urandom_range(10, 40);
            end
            phase_left--;
            retire_ready_i = (phase_mode == 0) ? 1'b1
                           : (phase_mode == 1) ? 1'($urandom_range(0, 1)) : 1'b0;

            // Sample mid low phase, well before the next rising edge
            #10;
            // Buffer plus retire register hold ROB_DEPTH+1 results at most
            check_flag("fetch_ready_o", fetch_ready_o,
                       (accepted_cnt - retired_cnt) <= `ROB_DEPTH);
            if (hold_q) begin
                check_flag("retire_valid_o under back-pressure", retire_valid_o, 1'b1);
                check_rd("retire_rd_idx_o under back-pressure", retire_rd_idx_o, held_rd);
                check_value("retire_value_o under back-pressure", retire_value_o, held_value);
            end
            fetch_fire  = fetch_valid_i && fetch_ready_o;
            retire_fire = retire_valid_o && retire_ready_i;
            if (retire_fire) begin
                if (expected_q.size() == 0) begin
                    stop_with_error("Retire handshake seen with no instruction outstanding");
                end
                check_rd("retire_rd_idx_o", retire_rd_idx_o, expected_q[0].rd_idx);
                check_value("retire_value_o", retire_value_o, expected_q[0].value);
                void'(expected_q.pop_front());
                retired_cnt++;
            end
            hold_q     = retire_valid_o && !retire_ready_i;
            held_rd    = retire_rd_idx_o;
            held_value = retire_value_o;
            if (fetch_fire) begin
                execute_model();
                accepted_cnt++;
            end
            cycle_cnt++;
        end

        if (retired_cnt == NUM_INSTR && expected_q.size() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            stop_with_error($sformatf("Timeout after %0d cycles, only %0d of %0d instructions retired",
                                      cycle_cnt, retired_cnt, NUM_INSTR));
        end
    end

endmodule

//--- src/backend.sv
// Backend top level: connects issue stage, reorder buffer and commit stage to fetch and retire ports
`timescale 1ns/1ps

module backend import backend_pkg::*; (
    // Clock and reset
    input  logic      clk_i,
    input  logic      rst_n_i,

    // Fetch port
    input  logic      fetch_valid_i,
    input  instr_t    fetch_instr_i,
    output logic      fetch_ready_o,

    // Retire port
    input  logic      retire_ready_i,
    output logic      retire_valid_o,
    output reg_idx_t  retire_rd_idx_o,
    output word_t     retire_value_o
);

    // ------------------------------------------------
    // Internal links
    // ------------------------------------------------
    rob_alloc_if alloc_if ();
    rob_fwd_if   fwd_if ();
    commit_if    comm_if ();
    rf_read_if   rf_if ();

    // ------------------------------------------------
    // Stages
    // ------------------------------------------------
    //  fetch > ISSUE > ROB > COMMIT > retire
    issue_stage u_issue_stage (
        .clk_i          (clk_i          ),
        .rst_n_i        (rst_n_i        ),
        .fetch_valid_i  (fetch_valid_i  ),
        .fetch_instr_i  (fetch_instr_i  ),
        .fetch_ready_o  (fetch_ready_o  ),
        .alloc_o        (alloc_if.issue ),
        .fwd_o          (fwd_if.issue   ),
        .rf_o           (rf_if.issue    ),
        .commit_i       (comm_if.monitor)
    );

    rob u_rob (
        .clk_i          (clk_i          ),
        .rst_n_i        (rst_n_i        ),
        .alloc_i        (alloc_if.rob   ),
        .fwd_i          (fwd_if.rob     ),
        .commit_o       (comm_if.rob    )
    );

    commit_stage u_commit_stage (
        .clk_i          (clk_i          ),
        .rst_n_i        (rst_n_i        ),
        .commit_i       (comm_if.commit ),
        .rf_i           (rf_if.commit   ),
        .retire_ready_i (retire_ready_i ),
        .retire_valid_o (retire_valid_o ),
        .retire_rd_idx_o(retire_rd_idx_o),
        .retire_value_o (retire_value_o )
    );

endmodule

//--- src/commit_stage.sv
// Commit stage: architectural register file plus the retire output register with back-pressure
`timescale 1ns/1ps
`include "backend_cfg.svh"

module commit_stage import backend_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,

    commit_if.commit     commit_i,
    rf_read_if.commit    rf_i,

    // Retire port
    input  logic         retire_ready_i,
    output logic         retire_valid_o,
    output reg_idx_t     retire_rd_idx_o,
    output word_t        retire_value_o
);

    logic commit_fire;

    // Free slot, or the held result leaves at this edge
    assign commit_i.ready = !retire_valid_o || retire_ready_i;
    assign commit_fire    = commit_i.valid && commit_i.ready;

    // ------------------------------------------------
    // Architectural register file
    // ------------------------------------------------
    word_t regs_q [`REG_NUM];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs_q[i] <= '0;
            end
        end else if (commit_fire && (commit_i.entry.rd_idx != '0)) begin
            regs_q[commit_i.entry.rd_idx] <= commit_i.entry.value;
        end
    end

    // x0 is never written so it reads as zero
    assign rf_i.rs1_value = regs_q[rf_i.rs1_idx];
    assign rf_i.rs2_value = regs_q[rf_i.rs2_idx];

    // ------------------------------------------------
    // Retire output register
    // ------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            retire_valid_o <= 1'b0;
        end else if (commit_fire) begin
            retire_valid_o <= 1'b1;
        end else if (retire_ready_i) begin
            retire_valid_o <= 1'b0;
        end
    end

    // Payload holds until the next handshake
    always_ff @(posedge clk_i) begin
        if (commit_fire) begin
            retire_rd_idx_o <= commit_i.entry.rd_idx;
            retire_value_o  <= commit_i.entry.value;
        end
    end

endmodule

//--- src/rob.sv
// Reorder buffer: circular store of completed results, drained in program order by the commit stage
`timescale 1ns/1ps
`include "backend_cfg.svh"

module rob import backend_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,

    rob_alloc_if.rob  alloc_i,
    rob_fwd_if.rob    fwd_i,
    commit_if.rob     commit_o
);

    localparam logic [`ROB_IDX_LEN:0] FULL_CNT = `ROB_DEPTH;

    // ------------------------------------------------
    // Storage and pointers
    // ------------------------------------------------
    rob_entry_t              entries [`ROB_DEPTH];
    rob_idx_t                head_q;
    rob_idx_t                tail_q;
    logic [`ROB_IDX_LEN:0]   count_q;
    logic                    alloc_fire;
    logic                    commit_fire;

    assign alloc_fire  = alloc_i.valid && alloc_i.ready;
    assign commit_fire = commit_o.valid && commit_o.ready;

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc_fire) begin
                tail_q <= tail_q + 1'b1;
            end
            if (commit_fire) begin
                head_q <= head_q + 1'b1;
            end
            case ({alloc_fire, commit_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_fire) begin
            entries[tail_q] <= alloc_i.entry;
        end
    end

    // ------------------------------------------------
    // Outputs
    // ------------------------------------------------
    assign alloc_i.ready    = (count_q != FULL_CNT);
    assign alloc_i.tail_idx = tail_q;

    // Owner slots always hold a live entry while the register is busy
    assign fwd_i.rs1_value  = entries[fwd_i.rs1_rob_idx].value;
    assign fwd_i.rs2_value  = entries[fwd_i.rs2_rob_idx].value;

    assign commit_o.valid    = (count_q != '0);
    assign commit_o.entry    = entries[head_q];
    assign commit_o.head_idx = head_q;

endmodule

//--- src/issue_stage.sv
// Issue stage: decodes fetched words, tracks register ownership, selects operands and runs the ALU
`timescale 1ns/1ps
`include "backend_cfg.svh"

module issue_stage import backend_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,

    // Fetch port
    input  logic              fetch_valid_i,
    input  instr_t            fetch_instr_i,
    output logic              fetch_ready_o,

    // Reorder buffer and register file
    rob_alloc_if.issue        alloc_o,
    rob_fwd_if.issue          fwd_o,
    rf_read_if.issue          rf_o,
    commit_if.monitor         commit_i
);

    // ------------------------------------------------
    // Decode
    // ------------------------------------------------
    logic       is_op;
    logic       is_op_imm;
    logic       funct3_ok;
    logic       supported;
    logic [2:0] funct3;
    reg_idx_t   rs1_idx;
    reg_idx_t   rs2_idx;
    reg_idx_t   rd_idx;
    word_t      imm_value;

    assign is_op     = (fetch_instr_i.r.opcode == `OPCODE_OP);
    assign is_op_imm = (fetch_instr_i.i.opcode == `OPCODE_OP_IMM);

    // Fields common to both layouts sit at the same bit positions
    assign funct3    = fetch_instr_i.r.funct3;
    assign rs1_idx   = fetch_instr_i.r.rs1;
    assign rs2_idx   = fetch_instr_i.r.rs2;
    assign imm_value = {{(`XLEN-12){fetch_instr_i.i.imm[11]}}, fetch_instr_i.i.imm};

    always_comb begin
        case (funct3)
            `FUNCT3_ADD, `FUNCT3_SLT, `FUNCT3_XOR,
            `FUNCT3_OR, `FUNCT3_AND: funct3_ok = 1'b1;
            default:                 funct3_ok = 1'b0;
        endcase
    end

    assign supported = (is_op || is_op_imm) && funct3_ok;
    // Unsupported encodings retire to x0
    assign rd_idx    = supported ? fetch_instr_i.r.rd : '0;

    // ------------------------------------------------
    // Register status table
    // ------------------------------------------------
    logic [`REG_NUM-1:0] busy_q;
    rob_idx_t            owner_q [`REG_NUM];
    logic                alloc_fire;
    logic                commit_fire;
    logic                rd_claim;

    assign alloc_fire  = alloc_o.valid && alloc_o.ready;
    assign commit_fire = commit_i.valid && commit_i.ready;
    // x0 never gets an owner, so its reads always come from the register file
    assign rd_claim    = alloc_fire && (rd_idx != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q <= '0;
        end else begin
            // Release only when the retiring slot is still the latest writer
            if (commit_fire && (owner_q[commit_i.entry.rd_idx] == commit_i.head_idx)) begin
                busy_q[commit_i.entry.rd_idx] <= 1'b0;
            end
            // A new claim at the same edge takes priority
            if (rd_claim) begin
                busy_q[rd_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_claim) begin
            owner_q[rd_idx] <= alloc_o.tail_idx;
        end
    end

    // ------------------------------------------------
    // Operand selection
    // ------------------------------------------------
    word_t op_a;
    word_t op_b;

    assign rf_o.rs1_idx     = rs1_idx;
    assign rf_o.rs2_idx     = rs2_idx;
    assign fwd_o.rs1_rob_idx = owner_q[rs1_idx];
    assign fwd_o.rs2_rob_idx = owner_q[rs2_idx];

    assign op_a = busy_q[rs1_idx] ? fwd_o.rs1_value : rf_o.rs1_value;
    assign op_b = is_op_imm ? imm_value
                : (busy_q[rs2_idx] ? fwd_o.rs2_value : rf_o.rs2_value);

    // ------------------------------------------------
    // ALU
    // ------------------------------------------------
    word_t alu_result;

    always_comb begin
        alu_result = '0;
        if (supported) begin
            case (funct3)
                `FUNCT3_ADD: alu_result = (is_op && fetch_instr_i.r.funct7[5]) ? op_a - op_b
                                                                              : op_a + op_b;
                `FUNCT3_SLT: alu_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
                `FUNCT3_XOR: alu_result = op_a ^ op_b;
                `FUNCT3_OR:  alu_result = op_a | op_b;
                `FUNCT3_AND: alu_result = op_a & op_b;
                default:     alu_result = '0;
            endcase
        end
    end

    // Results are complete at allocation
    assign alloc_o.valid        = fetch_valid_i;
    assign alloc_o.entry.rd_idx = rd_idx;
    assign alloc_o.entry.value  = alu_result;
    assign fetch_ready_o        = alloc_o.ready;

endmodule

//--- src/backend_if.sv
// Interfaces with modports that link the issue stage, the reorder buffer and the commit stage
`timescale 1ns/1ps

// Issue stage allocates one entry per accepted instruction
interface rob_alloc_if import backend_pkg::*; ();
    logic       valid;
    logic       ready;
    rob_entry_t entry;
    rob_idx_t   tail_idx;

    modport issue (output valid, entry, input ready, tail_idx);
    modport rob   (input valid, entry, output ready, tail_idx);
endinterface

// Combinational operand forwarding out of the buffer
interface rob_fwd_if import backend_pkg::*; ();
    rob_idx_t rs1_rob_idx;
    rob_idx_t rs2_rob_idx;
    word_t    rs1_value;
    word_t    rs2_value;

    modport issue (output rs1_rob_idx, rs2_rob_idx, input rs1_value, rs2_value);
    modport rob   (input rs1_rob_idx, rs2_rob_idx, output rs1_value, rs2_value);
endinterface

// Buffer head towards the commit stage
interface commit_if import backend_pkg::*; ();
    logic       valid;
    logic       ready;
    rob_entry_t entry;
    rob_idx_t   head_idx;

    modport rob     (output valid, entry, head_idx, input ready);
    modport commit  (input valid, entry, head_idx, output ready);
    // Issue stage watches retirement to release busy registers
    modport monitor (input valid, entry, head_idx, ready);
endinterface

// Architectural register file read ports
interface rf_read_if import backend_pkg::*; ();
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_value;
    word_t    rs2_value;

    modport issue  (output rs1_idx, rs2_idx, input rs1_value, rs2_value);
    modport commit (input rs1_idx, rs2_idx, output rs1_value, rs2_value);
endinterface

//--- src/backend_pkg.sv
// Shared backend types for instruction words, indices and buffer entries, imported by the RTL
`include "backend_cfg.svh"

package backend_pkg;

    // ------------------------------------------------
    // Basic words and indices
    // ------------------------------------------------
    typedef logic [`XLEN-1:0]        word_t;
    typedef logic [`REG_IDX_LEN-1:0] reg_idx_t;
    typedef logic [`ROB_IDX_LEN-1:0] rob_idx_t;

    // ------------------------------------------------
    // Instruction layouts
    // ------------------------------------------------

    // Register-register format
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_type_t;

    // Register-immediate format
    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_type_t;

    // Same fetched word, layout picked by opcode
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_t;

    // Reorder buffer slot contents
    typedef struct packed {
        reg_idx_t rd_idx;
        word_t    value;
    } rob_entry_t;

endpackage

//--- src/backend_cfg.svh
// Backend widths, depths and opcode/funct3 encodings, included by the package and RTL files
`ifndef BACKEND_CFG_SVH
`define BACKEND_CFG_SVH

// Datapath and register file sizes
`define XLEN            32
`define REG_NUM         32
`define REG_IDX_LEN     5

// Reorder buffer, depth must be a power of two
`define ROB_DEPTH       8
`define ROB_IDX_LEN     3

// Supported major opcodes
`define OPCODE_OP       7'b0110011
`define OPCODE_OP_IMM   7'b0010011

// Supported funct3 codes (SUB shares ADD)
`define FUNCT3_ADD      3'b000
`define FUNCT3_SLT      3'b010
`define FUNCT3_XOR      3'b100
`define FUNCT3_OR       3'b110
`define FUNCT3_AND      3'b111

`endif
